//--- hw/rt_geom_pkg.sv
////////////////////
// rt_geom_pkg
// Q8.8 fixed-point geometry types for the intersection math
////////////////////

package rt_geom_pkg;

  // signed Q8.8
  typedef logic signed [15:0] fixed_t;

  typedef struct packed {
    fixed_t x;
    fixed_t y;
    fixed_t z;
  } vec3_t;

  // world to unit-triangle space, m[3*row + col]
  typedef struct packed {
    fixed_t [0:8] m;
    vec3_t        tr;
  } tri_cacheline_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_vec_t;

  // barycentric coordinates of the hit point
  typedef struct packed {
    fixed_t u;
    fixed_t v;
  } bari_uv_t;

  // 1 multiply + 1 sum + 1 sign split + 16 divide steps + 1 bary/compare
  localparam int MATH_LATENCY = 20;

endpackage

//--- hw/rt_pipe_pkg.sv
////////////////////
// rt_pipe_pkg
// records passed between cache, intersection, list and leaf arbiter
////////////////////

package rt_pipe_pkg;

  typedef struct packed {
    logic [7:0] ray_id;
    logic [3:0] ss_id;   // shader slot
  } ray_info_t;

  typedef logic [15:0] tri_id_t;

  // leaf-list counters
  typedef struct packed {
    logic [7:0] lnum_left;  // triangles still to test in this leaf
    logic [7:0] lindex;     // position in the leaf list
  } ln_tri_t;

  typedef struct packed {
    rt_geom_pkg::tri_cacheline_t tri_cacheline;
    rt_geom_pkg::ray_vec_t       ray_vec;
    ray_info_t                   ray_info;
    tri_id_t                     tri_id;
    ln_tri_t                     ln_tri;
  } icache_to_int_t;

  typedef struct packed {
    ray_info_t             ray_info;
    tri_id_t               tri_id;
    logic                  hit;
    logic                  is_last;
    rt_geom_pkg::fixed_t   t_int;
    rt_geom_pkg::bari_uv_t uv;
  } int_to_list_t;

  typedef struct packed {
    ray_info_t ray_info;
    ln_tri_t   ln_tri;
  } leaf_info_t;

  // travels in the delay line beside the math
  typedef struct packed {
    ray_info_t ray_info;
    tri_id_t   tri_id;
    ln_tri_t   ln_tri;
  } side_t;

endpackage

//--- hw/int_math.sv
////////////////////
// int_math
// pipelined ray transform, restoring divide for t and barycentric hit test
////////////////////
`timescale 1ns/10ps

module int_math #(
  parameter rt_geom_pkg::fixed_t EPSILON = 16'sd16
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  rt_geom_pkg::tri_cacheline_t cacheline,
  input  rt_geom_pkg::ray_vec_t       ray_vec,
  output logic                        hit,
  output rt_geom_pkg::fixed_t         t_int,
  output rt_geom_pkg::bari_uv_t       uv
);

  localparam int DIV_STEPS = 16;

  typedef struct packed {
    logic signed [31:0] ox;
    logic signed [31:0] oy;
    logic signed [31:0] dx;
    logic signed [31:0] dy;
    logic               neg;  // quotient sign
    logic               ovf;  // |t| >= 65536 or den zero
  } carry_t;

  // last stage loads from vld[MATH_LATENCY-2] and keeps no valid of its own
  logic [rt_geom_pkg::MATH_LATENCY-2:0] vld;

  rt_geom_pkg::fixed_t org [0:2];
  rt_geom_pkg::fixed_t dir [0:2];
  logic signed [31:0]  po [0:8];
  logic signed [31:0]  pd [0:8];
  rt_geom_pkg::fixed_t s1_tr [0:2];
  logic signed [31:0]  s2_o [0:2];
  logic signed [31:0]  s2_d [0:2];
  logic signed [31:0]  num;
  logic [31:0]         num_abs, den_abs;
  logic [47:0]         rem [0:DIV_STEPS-1];
  logic [31:0]         dvs [0:DIV_STEPS-1];
  logic [15:0]         quo [0:DIV_STEPS];
  carry_t              cry [0:DIV_STEPS];
  rt_geom_pkg::fixed_t t_s, u_c, v_c;
  logic signed [47:0]  tu, tv, u_w, v_w;
  logic signed [16:0]  uv_sum;
  logic                ok;

  function automatic logic signed [31:0] fx_mul(input rt_geom_pkg::fixed_t a,
                                                input rt_geom_pkg::fixed_t b);
    logic signed [31:0] p;
    p = a * b;
    return p >>> 8;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) vld <= '0;
    else         vld <= {vld[rt_geom_pkg::MATH_LATENCY-3:0], in_valid};
  end

  always_comb begin
    org = '{ray_vec.origin.x, ray_vec.origin.y, ray_vec.origin.z};
    dir = '{ray_vec.dir.x, ray_vec.dir.y, ray_vec.dir.z};
  end

  ////////////////////
  // transform
  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int i = 0; i < 9; i++) begin
        po[i] <= fx_mul(cacheline.m[i], org[i % 3]);
        pd[i] <= fx_mul(cacheline.m[i], dir[i % 3]);
      end
      s1_tr <= '{cacheline.tr.x, cacheline.tr.y, cacheline.tr.z};
    end
  end

  always_ff @(posedge clk) begin
    if (vld[0]) begin
      for (int r = 0; r < 3; r++) begin
        s2_o[r] <= po[3*r] + po[3*r+1] + po[3*r+2] + s1_tr[r];
        s2_d[r] <= pd[3*r] + pd[3*r+1] + pd[3*r+2];
      end
    end
  end

  // t = -oz / dz, divided as magnitudes
  always_comb begin
    num     = -s2_o[2];
    num_abs = num[31] ? -num : num;
    den_abs = s2_d[2][31] ? -s2_d[2] : s2_d[2];
  end

  always_ff @(posedge clk) begin
    if (vld[1]) begin
      rem[0]     <= {8'b0, num_abs, 8'b0};   // |num| * 256
      dvs[0]     <= den_abs;
      quo[0]     <= '0;
      cry[0].ox  <= s2_o[0];
      cry[0].oy  <= s2_o[1];
      cry[0].dx  <= s2_d[0];
      cry[0].dy  <= s2_d[1];
      cry[0].neg <= num[31] ^ s2_d[2][31];
      cry[0].ovf <= {8'b0, num_abs, 8'b0} >= {den_abs, 16'b0};  // also true for den zero
    end
  end

  ////////////////////
  // restoring divider, one quotient bit per stage, msb first
  for (genvar k = 0; k < DIV_STEPS; k++) begin : g_div
    logic [47:0] trial;
    logic        fits;

    assign trial = {16'b0, dvs[k]} << (DIV_STEPS - 1 - k);
    assign fits  = rem[k] >= trial;

    always_ff @(posedge clk) begin
      if (vld[2 + k]) begin
        quo[k+1] <= {quo[k][14:0], fits};
        cry[k+1] <= cry[k];
      end
    end

    if (k < DIV_STEPS - 1) begin : g_fwd
      always_ff @(posedge clk) begin
        if (vld[2 + k]) begin
          rem[k+1] <= fits ? rem[k] - trial : rem[k];
          dvs[k+1] <= dvs[k];
        end
      end
    end
  end

  ////////////////////
  // barycentric test and epsilon compare
  always_comb begin
    ok     = ~(cry[DIV_STEPS].ovf | quo[DIV_STEPS][15]);  // |t| must fit in 15 bits
    t_s    = cry[DIV_STEPS].neg ? -quo[DIV_STEPS] : quo[DIV_STEPS];
    tu     = t_s * cry[DIV_STEPS].dx;   // t times transformed dir
    tv     = t_s * cry[DIV_STEPS].dy;
    u_w    = cry[DIV_STEPS].ox + (tu >>> 8);
    v_w    = cry[DIV_STEPS].oy + (tv >>> 8);
    u_c    = u_w[15:0];
    v_c    = v_w[15:0];
    uv_sum = u_c + v_c;
  end

  // out-of-range t reports zeros like a zero denominator
  always_ff @(posedge clk) begin
    if (vld[rt_geom_pkg::MATH_LATENCY-2]) begin
      hit   <= ok & (t_s > EPSILON) & ~u_c[15] & ~v_c[15] & (uv_sum <= 17'sd256);
      t_int <= ok ? t_s : '0;
      uv.u  <= ok ? u_c : '0;
      uv.v  <= ok ? v_c : '0;
    end
  end

endmodule

//--- hw/pipe_valid_stall.sv
////////////////////
// pipe_valid_stall
// side-data delay line matched to the math, credit stall upstream
////////////////////
`timescale 1ns/10ps

module pipe_valid_stall #(
  parameter  int FIFO_DEPTH = 32,
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               us_valid,
  input  rt_pipe_pkg::side_t us_data,
  output logic               us_stall,
  output logic               ds_valid,
  output rt_pipe_pkg::side_t ds_data,
  input  logic [CNT_W-1:0]   num_in_fifo   // fill of the fuller output FIFO
);

  localparam int LAT   = rt_geom_pkg::MATH_LATENCY;
  localparam int FLT_W = $clog2(LAT + 1);

  logic [LAT-1:0]     vld;
  rt_pipe_pkg::side_t sd [0:LAT-1];
  logic [FLT_W-1:0]   in_flight;
  logic [31:0]        credit;
  logic               accept;

  assign accept   = us_valid & ~us_stall;
  assign credit   = 32'(in_flight) + 32'(num_in_fifo);
  assign us_stall = credit >= 32'(FIFO_DEPTH);  // registered state only

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld       <= '0;
      in_flight <= '0;
    end else begin
      vld       <= {vld[LAT-2:0], accept};
      in_flight <= in_flight + FLT_W'(accept) - FLT_W'(vld[LAT-1]);
    end
  end

  always_ff @(posedge clk) begin
    sd[0] <= us_data;
    for (int i = 1; i < LAT; i++) sd[i] <= sd[i-1];
  end

  assign ds_valid = vld[LAT-1];
  assign ds_data  = sd[LAT-1];

endmodule

//--- hw/sync_fifo.sv
////////////////////
// sync_fifo
// single-clock first-word-fall-through FIFO with fill count
////////////////////
`timescale 1ns/10ps

module sync_fifo #(
  parameter  int WIDTH = 8,
  parameter  int DEPTH = 32,
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             full,
  output logic [CNT_W-1:0] used
);

  logic [WIDTH-1:0] mem [0:DEPTH-1];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic             wr_ok, rd_ok;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr_ok   = wr_en & ~full;
  assign rd_ok   = rd_en & ~empty;
  assign empty   = (used == '0);
  assign full    = (used == CNT_W'(DEPTH));
  assign rd_data = mem[rd_ptr];   // head is always on the output

  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (wr_ok) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);
      used <= used + CNT_W'(wr_ok) - CNT_W'(rd_ok);
    end
  end

endmodule

//--- hw/int_unit.sv
////////////////////
// int_unit
// triangle intersection stage with list and leaf arbiter result queues
////////////////////
`timescale 1ns/10ps

module int_unit #(
  parameter int                  FIFO_DEPTH = 32,
  parameter rt_geom_pkg::fixed_t EPSILON    = 16'sd16   // 0.0625
) (
  input  logic                        clk,
  input  logic                        arst_n,

  input  logic                        icache_to_int_valid,
  input  rt_pipe_pkg::icache_to_int_t icache_to_int_data,
  output logic                        icache_to_int_stall,

  output logic                        int_to_list_valid,
  output rt_pipe_pkg::int_to_list_t   int_to_list_data,
  input  logic                        int_to_list_stall,

  output logic                        int_to_larb_valid,
  output rt_pipe_pkg::leaf_info_t     int_to_larb_data,
  input  logic                        int_to_larb_stall
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic                      accept;
  rt_pipe_pkg::side_t        side_in, side_out;
  logic                      pipe_valid;
  logic                      hit;
  rt_geom_pkg::fixed_t       t_int;
  rt_geom_pkg::bari_uv_t     uv;
  logic                      is_last;
  rt_pipe_pkg::int_to_list_t list_in;
  rt_pipe_pkg::leaf_info_t   larb_in;
  logic                      list_wr, list_rd, list_empty, list_full;
  logic                      larb_wr, larb_rd, larb_empty, larb_full;
  logic [CNT_W-1:0]          list_used, larb_used, max_used;

  assign accept = icache_to_int_valid & ~icache_to_int_stall;

  ////////////////////
  // math and side data
  int_math #(.EPSILON(EPSILON)) int_math_i (
    .clk,
    .arst_n,
    .in_valid  (accept),
    .cacheline (icache_to_int_data.tri_cacheline),
    .ray_vec   (icache_to_int_data.ray_vec),
    .hit,
    .t_int,
    .uv
  );

  // counters advance before the delay line, both wrap
  always_comb begin
    side_in.ray_info         = icache_to_int_data.ray_info;
    side_in.tri_id           = icache_to_int_data.tri_id;
    side_in.ln_tri.lnum_left = icache_to_int_data.ln_tri.lnum_left - 8'd1;
    side_in.ln_tri.lindex    = icache_to_int_data.ln_tri.lindex + 8'd1;
  end

  assign max_used = (list_used > larb_used) ? list_used : larb_used;

  pipe_valid_stall #(.FIFO_DEPTH(FIFO_DEPTH)) pipe_i (
    .clk,
    .arst_n,
    .us_valid    (icache_to_int_valid),
    .us_data     (side_in),
    .us_stall    (icache_to_int_stall),
    .ds_valid    (pipe_valid),
    .ds_data     (side_out),
    .num_in_fifo (max_used)
  );

  ////////////////////
  // result routing
  assign is_last = (side_out.ln_tri.lnum_left == 8'd0);

  always_comb begin
    list_in.ray_info = side_out.ray_info;
    list_in.tri_id   = side_out.tri_id;
    list_in.hit      = hit;
    list_in.is_last  = is_last;
    list_in.t_int    = t_int;
    list_in.uv       = uv;
    larb_in.ray_info = side_out.ray_info;
    larb_in.ln_tri   = side_out.ln_tri;
  end

  assign list_wr = pipe_valid & (hit | is_last);
  assign larb_wr = pipe_valid & ~is_last;     // more triangles left in the leaf

  sync_fifo #(.WIDTH($bits(rt_pipe_pkg::int_to_list_t)), .DEPTH(FIFO_DEPTH)) list_fifo (
    .clk,
    .arst_n,
    .wr_en   (list_wr),
    .wr_data (list_in),
    .rd_en   (list_rd),
    .rd_data (int_to_list_data),
    .empty   (list_empty),
    .full    (list_full),
    .used    (list_used)
  );

  sync_fifo #(.WIDTH($bits(rt_pipe_pkg::leaf_info_t)), .DEPTH(FIFO_DEPTH)) larb_fifo (
    .clk,
    .arst_n,
    .wr_en   (larb_wr),
    .wr_data (larb_in),
    .rd_en   (larb_rd),
    .rd_data (int_to_larb_data),
    .empty   (larb_empty),
    .full    (larb_full),
    .used    (larb_used)
  );

  assign int_to_list_valid = ~list_empty;
  assign list_rd           = int_to_list_valid & ~int_to_list_stall;
  assign int_to_larb_valid = ~larb_empty;
  assign larb_rd           = int_to_larb_valid & ~int_to_larb_stall;

endmodule

//--- testbench/int_unit_properties.sv
////////////////////
// int_unit_properties
// handshake and FIFO safety assertions, bound into int_unit
////////////////////
`timescale 1ns/10ps

module int_unit_properties (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      int_to_list_valid,
  input rt_pipe_pkg::int_to_list_t int_to_list_data,
  input logic                      int_to_list_stall,
  input logic                      int_to_larb_valid,
  input rt_pipe_pkg::leaf_info_t   int_to_larb_data,
  input logic                      int_to_larb_stall,
  input logic                      list_wr,
  input logic                      list_full,
  input logic                      larb_wr,
  input logic                      larb_full
);

  list_hold: assert property (@(posedge clk) disable iff (!arst_n)
    int_to_list_valid && int_to_list_stall |=> int_to_list_valid && $stable(int_to_list_data))
    else $error("list output changed while stalled");

  larb_hold: assert property (@(posedge clk) disable iff (!arst_n)
    int_to_larb_valid && int_to_larb_stall |=> int_to_larb_valid && $stable(int_to_larb_data))
    else $error("larb output changed while stalled");

  // credit stall must keep both queues from overflowing
  list_no_ovf: assert property (@(posedge clk) disable iff (!arst_n) !(list_wr && list_full))
    else $error("write into full list FIFO");

  larb_no_ovf: assert property (@(posedge clk) disable iff (!arst_n) !(larb_wr && larb_full))
    else $error("write into full larb FIFO");

  rst_idle: assert property (@(posedge clk) !arst_n |-> !int_to_list_valid && !int_to_larb_valid)
    else $error("output valid high during reset");

endmodule

bind int_unit int_unit_properties props_i (
  .clk, .arst_n,
  .int_to_list_valid, .int_to_list_data, .int_to_list_stall,
  .int_to_larb_valid, .int_to_larb_data, .int_to_larb_stall,
  .list_wr, .list_full, .larb_wr, .larb_full
);

//--- testbench/tb_int_unit.sv
////////////////////
// tb_int_unit
// random stimulus, reference model and in-order output checks
////////////////////
`timescale 1ns/10ps

module tb_int_unit;

  localparam int                  FIFO_DEPTH = 32;
  localparam rt_geom_pkg::fixed_t EPSILON    = 16'sd16;
  localparam logic [31:0]         SEED       = 32'd76916;
  localparam int                  TIMEOUT    = 2000;   // cycles per wait loop

  logic                        clk;
  logic                        arst_n;
  logic                        icache_to_int_valid;
  rt_pipe_pkg::icache_to_int_t icache_to_int_data;
  logic                        icache_to_int_stall;
  logic                        int_to_list_valid;
  rt_pipe_pkg::int_to_list_t   int_to_list_data;
  logic                        int_to_list_stall;
  logic                        int_to_larb_valid;
  rt_pipe_pkg::leaf_info_t     int_to_larb_data;
  logic                        int_to_larb_stall;

  rt_pipe_pkg::int_to_list_t list_q [$];
  rt_pipe_pkg::leaf_info_t   larb_q [$];
  rt_pipe_pkg::int_to_list_t exp_list;
  rt_pipe_pkg::leaf_info_t   exp_larb;
  logic [31:0] stim_rng, stall_rng;
  int          cyc, acc_cyc, hold_until, wait_n;
  bit          rand_stall, hold_now, saw_stall;

  int_unit #(.FIFO_DEPTH(FIFO_DEPTH), .EPSILON(EPSILON)) int_unit_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic int rnd(input int lo, input int hi);
    stim_rng = xorshift32(stim_rng);
    return lo + int'(stim_rng % (hi - lo + 1));
  endfunction

  task automatic fail_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  ////////////////////
  // reference model, applied at accept
  function automatic void predict(input rt_pipe_pkg::icache_to_int_t req);
    longint org [0:2];
    longint tro [0:2];
    longint trd [0:2];
    longint dr  [0:2];
    longint num, den, q, t;
    rt_geom_pkg::fixed_t u, v;
    logic hit;
    logic [7:0] left;
    rt_pipe_pkg::int_to_list_t lr;
    rt_pipe_pkg::leaf_info_t br;
    org = '{req.ray_vec.origin.x, req.ray_vec.origin.y, req.ray_vec.origin.z};
    dr  = '{req.ray_vec.dir.x, req.ray_vec.dir.y, req.ray_vec.dir.z};
    tro = '{req.tri_cacheline.tr.x, req.tri_cacheline.tr.y, req.tri_cacheline.tr.z};
    trd = '{0, 0, 0};
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        tro[r] += (longint'($signed(req.tri_cacheline.m[3*r+c])) * org[c]) >>> 8;
        trd[r] += (longint'($signed(req.tri_cacheline.m[3*r+c])) * dr[c]) >>> 8;
      end
    end
    num = -tro[2];
    den = trd[2];
    q   = 0;
    if (den != 0) q = ((num < 0 ? -num : num) * 256) / (den < 0 ? -den : den);
    if (den == 0 || q > 32767) begin   // no usable t, zeros reported
      t   = 0;
      u   = '0;
      v   = '0;
      hit = 1'b0;
    end else begin
      t   = ((num < 0) != (den < 0)) ? -q : q;
      u   = 16'(tro[0] + ((t * trd[0]) >>> 8));
      v   = 16'(tro[1] + ((t * trd[1]) >>> 8));
      hit = (t > EPSILON) && (u >= 0) && (v >= 0) && (int'(u) + int'(v) <= 256);
    end
    left          = req.ln_tri.lnum_left - 8'd1;
    lr.ray_info   = req.ray_info;
    lr.tri_id     = req.tri_id;
    lr.hit        = hit;
    lr.is_last    = (left == 8'd0);
    lr.t_int      = 16'(t);
    lr.uv.u       = u;
    lr.uv.v       = v;
    br.ray_info   = req.ray_info;
    br.ln_tri.lnum_left = left;
    br.ln_tri.lindex    = req.ln_tri.lindex + 8'd1;
    if (hit || left == 8'd0) list_q.push_back(lr);
    if (left != 8'd0) larb_q.push_back(br);
  endfunction

  // identity transform mostly, so hits and misses both show up
  function automatic rt_pipe_pkg::icache_to_int_t make_req(input int n);
    rt_pipe_pkg::icache_to_int_t req;
    int kind;
    req  = '0;
    kind = rnd(0, 7);
    for (int i = 0; i < 9; i++) begin
      if (kind == 7) req.tri_cacheline.m[i] = 16'(rnd(-300, 300));
      else           req.tri_cacheline.m[i] = (i % 4 == 0) ? 16'sd256 : 16'sd0;
    end
    if (kind == 7) begin
      req.tri_cacheline.tr.x = 16'(rnd(-512, 512));
      req.tri_cacheline.tr.y = 16'(rnd(-512, 512));
      req.tri_cacheline.tr.z = 16'(rnd(-512, 512));
    end
    req.ray_vec.origin.x = 16'(rnd(-40, 160));
    req.ray_vec.origin.y = 16'(rnd(-40, 160));
    req.ray_vec.origin.z = 16'(-rnd(64, 1024));
    req.ray_vec.dir.x    = 16'(rnd(-64, 64));
    req.ray_vec.dir.y    = 16'(rnd(-64, 64));
    req.ray_vec.dir.z    = 16'(rnd(64, 512));
    case (kind)
      4: begin                                   // t around epsilon
        req.ray_vec.origin.z = 16'(-rnd(0, 40));
        req.ray_vec.dir.z    = 16'sd512;
      end
      5: req.ray_vec.dir.z = 16'sd0;             // zero denominator
      6: req.ray_vec.dir.z = 16'(-rnd(64, 512)); // negative t
      default: ;
    endcase
    req.ray_info.ray_id   = 8'(rnd(0, 255));
    req.ray_info.ss_id    = 4'(rnd(0, 15));
    req.tri_id            = 16'(n);
    req.ln_tri.lnum_left  = 8'(rnd(0, 3));   // 0 wraps, 1 is last
    req.ln_tri.lindex     = 8'(rnd(0, 255));
    return req;
  endfunction

  // leaves valid high, returns just after the accept edge
  task automatic send_beat(input rt_pipe_pkg::icache_to_int_t req);
    int n;
    n = 0;
    icache_to_int_valid = 1'b1;
    icache_to_int_data  = req;
    @(negedge clk);
    while (icache_to_int_stall) begin
      n++;
      if (n > TIMEOUT) begin
        $display("input stall was never released");
        fail_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  ////////////////////
  // monitors
  always @(negedge clk) begin
    if (arst_n) begin
      if (icache_to_int_valid && icache_to_int_stall) saw_stall = 1'b1;
      if (icache_to_int_valid && !icache_to_int_stall) begin
        predict(icache_to_int_data);
        acc_cyc = cyc;
      end
      if (int_to_list_valid && !int_to_list_stall) begin
        assert (list_q.size() > 0) else begin
          $display("[ERROR] %0t list output gave a record that was not expected", $time);
          fail_run();
        end
        exp_list = list_q.pop_front();
        check_field("list.ray_info", 64'(int_to_list_data.ray_info), 64'(exp_list.ray_info));
        check_field("list.tri_id", 64'(int_to_list_data.tri_id), 64'(exp_list.tri_id));
        check_field("list.hit", 64'(int_to_list_data.hit), 64'(exp_list.hit));
        check_field("list.is_last", 64'(int_to_list_data.is_last), 64'(exp_list.is_last));
        check_field("list.t_int", 64'(int_to_list_data.t_int), 64'(exp_list.t_int));
        check_field("list.uv.u", 64'(int_to_list_data.uv.u), 64'(exp_list.uv.u));
        check_field("list.uv.v", 64'(int_to_list_data.uv.v), 64'(exp_list.uv.v));
      end
      if (int_to_larb_valid && !int_to_larb_stall) begin
        assert (larb_q.size() > 0) else begin
          $display("[ERROR] %0t larb output gave a record that was not expected", $time);
          fail_run();
        end
        exp_larb = larb_q.pop_front();
        check_field("larb.ray_info", 64'(int_to_larb_data.ray_info), 64'(exp_larb.ray_info));
        check_field("larb.lnum_left", 64'(int_to_larb_data.ln_tri.lnum_left),
                    64'(exp_larb.ln_tri.lnum_left));
        check_field("larb.lindex", 64'(int_to_larb_data.ln_tri.lindex),
                    64'(exp_larb.ln_tri.lindex));
      end
    end
  end

  // downstream stalls, decided at negedge and driven after the edge
  always begin
    @(negedge clk);
    hold_now  = cyc < hold_until;
    stall_rng = xorshift32(stall_rng);
    @(posedge clk);
    #1;
    int_to_list_stall = hold_now | (rand_stall & (stall_rng[1:0] == 2'b00));
    int_to_larb_stall = hold_now | (rand_stall & (stall_rng[3:2] == 2'b00));
  end

  initial begin
    arst_n              = 1'b0;
    icache_to_int_valid = 1'b0;
    icache_to_int_data  = '0;
    int_to_list_stall   = 1'b0;
    int_to_larb_stall   = 1'b0;
    stim_rng            = SEED;
    stall_rng           = ~SEED;
    rand_stall          = 1'b0;
    hold_until          = 0;
    saw_stall           = 1'b0;
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    assert (!int_to_list_valid && !int_to_larb_valid && !icache_to_int_stall) else begin
      $display("outputs or input stall not idle after reset");
      fail_run();
    end

    // single beat, latency to first output
    send_beat(make_req(0));
    icache_to_int_valid = 1'b0;
    wait_n = 0;
    @(negedge clk);
    while (!int_to_list_valid && !int_to_larb_valid) begin
      wait_n++;
      if (wait_n > TIMEOUT) begin
        $display("no output after the first beat");
        fail_run();
      end
      @(negedge clk);
    end
    check_field("first result latency", 64'(cyc - acc_cyc), 64'd21);

    // random traffic with random downstream stall
    @(posedge clk);
    #1 rand_stall = 1'b1;
    for (int i = 1; i <= 400; i++) begin
      send_beat(make_req(i));
      if (rnd(0, 3) == 0) begin
        icache_to_int_valid = 1'b0;
        @(posedge clk);
        #1;
      end
    end

    // long burst against blocked outputs
    rand_stall = 1'b0;
    hold_until = cyc + 150;
    saw_stall  = 1'b0;
    for (int i = 401; i <= 480; i++) send_beat(make_req(i));
    icache_to_int_valid = 1'b0;
    assert (saw_stall) else begin
      $display("input stall never rose while outputs were blocked");
      fail_run();
    end

    wait_n = 0;
    while (list_q.size() != 0 || larb_q.size() != 0) begin
      wait_n++;
      if (wait_n > TIMEOUT) begin
        $display("expected records never came out");
        fail_run();
      end
      @(negedge clk);
    end
    repeat (40) @(posedge clk);   // nothing extra may appear

    // drained unit holds no credit, so the input stall must be low
    if (list_q.size() != 0 || larb_q.size() != 0 || icache_to_int_stall) begin
      $display("expected queues not empty or input still stalled at the end");
      fail_run();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

//--- tb.f
hw/rt_geom_pkg.sv
hw/rt_pipe_pkg.sv
hw/int_math.sv
hw/pipe_valid_stall.sv
hw/sync_fifo.sv
hw/int_unit.sv
testbench/int_unit_properties.sv
testbench/tb_int_unit.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_int_unit
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
